// ==== source/aud_mem_pkg.sv ====
//////////////////////////////
// Audio stream memory side
// Word and address types, sample region location
// and burst size of the external memory port
//////////////////////////////

package aud_mem_pkg;

  // One memory data word
  typedef logic [15:0] mem_word_t;

  // Word address into external memory
  typedef logic [22:0] mem_addr_t;

  // Upper address bits of the sample region
  localparam logic [6:0] region_prefix = 7'b1101111;

  localparam int offset_bits = 16;  // Region offset width, wraps at 64K words

  localparam int burst_len = 4;     // Words returned per accepted request

endpackage

// ==== source/aud_sample_pkg.sv ====
//////////////////////////////
// Audio stream sample side
// DAC sample format, frame timing and FIFO sizing
//////////////////////////////

package aud_sample_pkg;

  // Offset binary DAC sample
  typedef logic [15:0] sample_t;

  localparam sample_t sample_mid = 16'h8000;  // Offset binary zero

  // clk_114 cycles per audio frame
  localparam int frame_period = 643;

  localparam int fifo_depth = 16;  // Words

  // Holds 0 to fifo_depth
  typedef logic [4:0] fifo_count_t;

endpackage

// ==== source/aud_fetch.sv ====
//////////////////////////////
// Audio fetch engine
// Walks the sample region in bursts and forwards
// each returned word to the FIFO
//////////////////////////////

module aud_fetch
  import aud_mem_pkg::*;
  import aud_sample_pkg::*;
(
  input  logic        clk_114,
  input  logic        reset,
  input  logic        enable,
  input  fifo_count_t fifo_free,
  output logic        mem_req,
  output mem_addr_t   mem_addr,
  input  logic        mem_ack,
  input  logic        mem_fill,
  input  mem_word_t   mem_data,
  output logic        push_valid,
  output mem_word_t   push_data
);

  logic [offset_bits-1:0]        offset;    // Next burst start in the region
  logic [$clog2(burst_len)-1:0]  word_cnt;  // Fill words seen in this burst
  logic                          busy;      // Burst accepted, words outstanding
  logic                          discard;   // Burst belongs to an abandoned stream
  logic                          accept;
  logic                          fill_in;
  logic                          last_word;
  logic                          room;

  assign accept    = mem_req && mem_ack;
  assign fill_in   = busy && mem_fill;
  assign last_word = word_cnt == ($clog2(burst_len))'(burst_len - 1);
  assign room      = fifo_free >= fifo_count_t'(burst_len);

  assign mem_addr   = {region_prefix, offset};
  assign push_valid = fill_in && enable && !discard;
  assign push_data  = mem_data;

  //////////////////////////////
  // Request side
  //////////////////////////////
  always_ff @(posedge clk_114) begin
    if (reset) begin
      mem_req <= 1'b0;
    end else if (!enable || accept) begin
      mem_req <= 1'b0;  // Drop a pending request when the stream stops
    end else if (!mem_req && !busy && room) begin
      mem_req <= 1'b1;
    end
  end

  //////////////////////////////
  // Burst tracking
  //////////////////////////////
  always_ff @(posedge clk_114) begin
    if (reset) begin
      busy     <= 1'b0;
      word_cnt <= '0;
      discard  <= 1'b0;
    end else begin
      if (accept) begin
        busy     <= 1'b1;
        word_cnt <= '0;
        discard  <= !enable;
      end else if (fill_in) begin
        word_cnt <= word_cnt + 1'b1;
        if (last_word) begin
          busy    <= 1'b0;
          discard <= 1'b0;
        end else if (!enable) begin
          discard <= 1'b1;
        end
      end else if (busy && !enable) begin
        discard <= 1'b1;  // Rest of this burst is dropped
      end
    end
  end

  // Offset wraps modulo the region size
  always_ff @(posedge clk_114) begin
    if (reset || !enable) begin
      offset <= '0;
    end else if (fill_in && last_word && !discard) begin
      offset <= offset + offset_bits'(burst_len);
    end
  end

endmodule

// ==== source/aud_fifo.sv ====
//////////////////////////////
// Audio word FIFO
// Circular buffer between fetch and player, with
// a free space count and a one cycle flush
//////////////////////////////

module aud_fifo
  import aud_mem_pkg::*;
  import aud_sample_pkg::*;
(
  input  logic        clk_114,
  input  logic        reset,
  input  logic        flush,
  input  logic        push_valid,
  output logic        push_ready,
  input  mem_word_t   push_data,
  output logic        pop_valid,
  input  logic        pop_ready,
  output mem_word_t   pop_data,
  output fifo_count_t free
);

  mem_word_t                      buffer [fifo_depth];
  logic [$clog2(fifo_depth)-1:0]  wr_ptr;
  logic [$clog2(fifo_depth)-1:0]  rd_ptr;
  fifo_count_t                    count;  // Words held
  logic                           push_en;
  logic                           pop_en;

  assign push_ready = count != fifo_count_t'(fifo_depth);
  assign pop_valid  = count != '0;
  assign pop_data   = buffer[rd_ptr];
  assign free       = fifo_count_t'(fifo_depth) - count;

  assign push_en = push_valid && push_ready && !flush;
  assign pop_en  = pop_valid && pop_ready && !flush;

  // Storage
  always_ff @(posedge clk_114) begin
    if (push_en) begin
      buffer[wr_ptr] <= push_data;
    end
  end

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////
  always_ff @(posedge clk_114) begin
    if (reset || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_en) wr_ptr <= wr_ptr + 1'b1;  // Wraps with the depth
      if (pop_en) rd_ptr <= rd_ptr + 1'b1;
      case ({push_en, pop_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== source/aud_player.sv ====
//////////////////////////////
// Audio sample player
// Frame ticker that pops a left and a right word per
// frame and turns them into offset binary DAC samples
//////////////////////////////

module aud_player
  import aud_mem_pkg::*;
  import aud_sample_pkg::*;
(
  input  logic      clk_114,
  input  logic      reset,
  input  logic      enable,
  input  logic      pop_valid,
  output logic      pop_ready,
  input  mem_word_t pop_data,
  output sample_t   left_sample,
  output sample_t   right_sample,
  output logic      sample_strobe,
  output logic      underrun
);

  logic [$clog2(frame_period)-1:0] frame_ctr;
  logic                            frame_last;
  logic                            right_phase;  // Right pop cycle
  logic                            left_miss;
  sample_t                         left_next;    // Left sample waiting for its pair

  // Memory words are little endian two's complement
  function automatic sample_t to_dac(input mem_word_t w);
    return {~w[7], w[6:0], w[15:8]};
  endfunction

  assign frame_last = frame_ctr == ($clog2(frame_period))'(frame_period - 1);
  assign pop_ready  = enable && (frame_last || right_phase);

  //////////////////////////////
  // Frame timing
  //////////////////////////////
  always_ff @(posedge clk_114) begin
    if (reset || !enable) begin
      frame_ctr   <= '0;
      right_phase <= 1'b0;
    end else begin
      frame_ctr   <= frame_last ? '0 : frame_ctr + 1'b1;
      right_phase <= frame_last;  // Right word follows at count 0
    end
  end

  // Left word held until the right one arrives
  always_ff @(posedge clk_114) begin
    if (enable && frame_last) begin
      left_next <= pop_valid ? to_dac(pop_data) : left_sample;
    end
  end

  //////////////////////////////
  // Output pair
  //////////////////////////////
  always_ff @(posedge clk_114) begin
    if (reset || !enable) begin
      left_sample   <= sample_mid;
      right_sample  <= sample_mid;
      sample_strobe <= 1'b0;
      underrun      <= 1'b0;
      left_miss     <= 1'b0;
    end else begin
      sample_strobe <= right_phase;
      underrun      <= right_phase && (left_miss || !pop_valid);
      if (frame_last) left_miss <= !pop_valid;
      if (right_phase) begin
        left_sample <= left_next;
        if (pop_valid) right_sample <= to_dac(pop_data);  // Else hold last value
      end
    end
  end

endmodule

// ==== source/aud_stream.sv ====
//////////////////////////////
// Auxiliary audio stream top
// Fetch engine, word FIFO and sample player
//////////////////////////////

module aud_stream
  import aud_mem_pkg::*;
  import aud_sample_pkg::*;
(
  input  logic      clk_114,
  input  logic      reset,
  input  logic      enable,
  output logic      mem_req,
  output mem_addr_t mem_addr,
  input  logic      mem_ack,
  input  logic      mem_fill,
  input  mem_word_t mem_data,
  output sample_t   left_sample,
  output sample_t   right_sample,
  output logic      sample_strobe,
  output logic      underrun
);

  logic        push_valid;
  logic        push_ready;
  mem_word_t   push_data;
  logic        pop_valid;
  logic        pop_ready;
  mem_word_t   pop_data;
  fifo_count_t fifo_free;

  aud_fetch u_fetch (
    .clk_114(clk_114), .reset(reset), .enable(enable), .fifo_free(fifo_free),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_fill(mem_fill),
    .mem_data(mem_data), .push_valid(push_valid), .push_data(push_data)
  );

  // FIFO empties whenever the stream is off
  aud_fifo u_fifo (
    .clk_114(clk_114), .reset(reset), .flush(!enable),
    .push_valid(push_valid), .push_ready(push_ready), .push_data(push_data),
    .pop_valid(pop_valid), .pop_ready(pop_ready), .pop_data(pop_data), .free(fifo_free)
  );

  aud_player u_player (
    .clk_114(clk_114), .reset(reset), .enable(enable),
    .pop_valid(pop_valid), .pop_ready(pop_ready), .pop_data(pop_data),
    .left_sample(left_sample), .right_sample(right_sample),
    .sample_strobe(sample_strobe), .underrun(underrun)
  );

endmodule

// ==== test/aud_stream_properties.sv ====
//////////////////////////////
// Audio stream properties
// Handshake and reset checks bound into the top level
//////////////////////////////

module aud_stream_properties
  import aud_mem_pkg::*;
(
  input logic      clk_114,
  input logic      reset,
  input logic      enable,
  input logic      mem_req,
  input mem_addr_t mem_addr,
  input logic      mem_ack,
  input logic      push_valid,
  input logic      push_ready,
  input logic      sample_strobe
);

  timeunit 1ns;
  timeprecision 100ps;

  int failures = 0;  // Failed assertions so far

  // Fetch asks only with room for a whole burst
  push_accepted: assert property (
    @(posedge clk_114) disable iff (reset) push_valid |-> push_ready
  ) else begin
    $error("Fill word pushed while the FIFO was full");
    failures++;
  end

  // Request held until the memory takes it
  req_held: assert property (
    @(posedge clk_114) disable iff (reset)
      mem_req && !mem_ack && enable |=> mem_req && $stable(mem_addr)
  ) else begin
    $error("mem_req dropped or mem_addr moved before mem_ack");
    failures++;
  end

  strobe_pulse: assert property (
    @(posedge clk_114) disable iff (reset) sample_strobe |=> !sample_strobe
  ) else begin
    $error("sample_strobe high for more than one cycle");
    failures++;
  end

  // Request low right after reset
  reset_clears_req: assert property (
    @(posedge clk_114) reset |=> !mem_req
  ) else begin
    $error("mem_req high in the cycle after reset");
    failures++;
  end

endmodule

// Attached to every aud_stream instance
bind aud_stream aud_stream_properties u_properties (
  .clk_114(clk_114), .reset(reset), .enable(enable),
  .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack),
  .push_valid(push_valid), .push_ready(push_ready), .sample_strobe(sample_strobe)
);

// ==== test/aud_stream_tb.sv ====
//////////////////////////////
// Audio stream testbench
// Burst memory model, stimulus table and checks
// of addresses and DAC samples
//////////////////////////////

module aud_stream_tb
  import aud_mem_pkg::*;
  import aud_sample_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    bit enable;
    bit stall;     // Random ack delays and fill gaps
    bit withhold;  // Memory never acknowledges
    int frames;
    bit underrun;  // Expected once the FIFO has drained
  } row_t;

  row_t rows [6] = '{
    '{1'b0, 1'b0, 1'b0, 2, 1'b0},
    '{1'b1, 1'b0, 1'b0, 10, 1'b0},
    '{1'b1, 1'b1, 1'b0, 10, 1'b0},
    '{1'b1, 1'b0, 1'b1, 11, 1'b1},
    '{1'b0, 1'b0, 1'b0, 2, 1'b0},
    '{1'b1, 1'b0, 1'b0, 8, 1'b0}   // Restart from word 0
  };

  logic      clk_114;
  logic      reset;
  logic      enable;
  logic      mem_req;
  mem_addr_t mem_addr;
  logic      mem_ack;
  logic      mem_fill;
  mem_word_t mem_data;
  sample_t   left_sample;
  sample_t   right_sample;
  logic      sample_strobe;
  logic      underrun;

  logic                   stall;
  logic                   withhold;
  int                     errors;
  int                     checks;
  int                     delivered;    // Fill words pushed since enable rose
  logic [offset_bits-1:0] next_offset;  // Expected start of the next burst

  aud_stream dut (.*);

  // Test pattern held in external memory
  function automatic mem_word_t memory_word(input mem_addr_t addr);
    return {addr[7:0], ~addr[7:0]};
  endfunction

  // Byte swap, then MSB flip from two's complement to offset binary
  function automatic sample_t to_offset_binary(input mem_word_t w);
    sample_t swapped;
    swapped = {w[7:0], w[15:8]};
    return swapped ^ 16'h8000;
  endfunction

  function automatic sample_t stream_sample(input int k);
    return to_offset_binary(memory_word({region_prefix, k[offset_bits-1:0]}));
  endfunction

  function automatic int total_frames();
    int sum;
    sum = 0;
    foreach (rows[i]) sum += rows[i].frames;
    return sum;
  endfunction

  task automatic compare_sample(input string name, input sample_t expected,
                                input sample_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_address(input string name, input mem_addr_t expected,
                               input mem_addr_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic match_flag(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic expect_idle();
    match_flag("mem_req", 1'b0, mem_req);
    match_flag("sample_strobe", 1'b0, sample_strobe);
    match_flag("underrun", 1'b0, underrun);
    compare_sample("left_sample", sample_mid, left_sample);
    compare_sample("right_sample", sample_mid, right_sample);
  endtask

  initial begin
    clk_114 = 1'b0;
    forever #20 clk_114 = ~clk_114;
  end

  //////////////////////////////
  // Memory model
  //////////////////////////////
  initial begin : memory_model
    int        delay;
    int        gap;
    mem_addr_t base;
    void'($urandom(32'hd4f7_96e5));
    mem_ack  = 1'b0;
    mem_fill = 1'b0;
    mem_data = '0;
    forever begin
      @(posedge clk_114);
      #2;
      if (mem_req && !withhold) begin
        delay = stall ? int'($urandom % 4) : 0;
        repeat (delay) begin
          @(posedge clk_114);
          #2;
        end
        if (mem_req && !withhold) begin  // Request may be gone by now
          base    = mem_addr;
          mem_ack = 1'b1;
          @(posedge clk_114);
          #2;
          mem_ack = 1'b0;
          for (int i = 0; i < burst_len; i++) begin
            gap = stall ? int'($urandom % 3) : 0;
            repeat (gap) begin
              @(posedge clk_114);
              #2;
            end
            mem_fill = 1'b1;
            mem_data = memory_word(base + mem_addr_t'(i));
            @(posedge clk_114);
            #2;
            mem_fill = 1'b0;
          end
        end
      end
    end
  end

  // Accepted requests walk the region a burst at a time
  always @(negedge clk_114) begin
    if (reset || !enable) begin
      next_offset = '0;
    end else if (mem_req && mem_ack) begin
      check_address("mem_addr", {region_prefix, next_offset}, mem_addr);
      next_offset = next_offset + offset_bits'(burst_len);
    end
  end

  // Words taken into the FIFO, one per fill cycle
  always @(posedge clk_114) begin
    if (reset || !enable) begin
      delivered <= 0;
    end else if (mem_fill) begin
      delivered <= delivered + 1;
    end
  end

  initial begin : watchdog
    int limit;
    int cycles;
    limit  = total_frames() * frame_period + 200;
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk_114);
      cycles++;
    end
    $display("Timeout: run still busy after %0d clock cycles", cycles);
    $display("Finished with errors");
    $finish;
  end

  //////////////////////////////
  // Stimulus table
  //////////////////////////////
  initial begin : stimulus
    int      k;  // Next expected stream word
    logic    starved;
    logic    seen_underrun;
    sample_t exp_left;
    sample_t exp_right;
    reset     = 1'b1;
    enable    = 1'b0;
    stall     = 1'b0;
    withhold  = 1'b0;
    errors    = 0;
    checks    = 0;
    k         = 0;
    exp_left  = sample_mid;
    exp_right = sample_mid;
    repeat (2) @(posedge clk_114);
    #2 reset = 1'b0;
    @(negedge clk_114);
    expect_idle();
    foreach (rows[r]) begin
      stall    = rows[r].stall;  // Model controls change away from its sample point
      withhold = rows[r].withhold;
      @(posedge clk_114);
      #2;
      if (rows[r].enable && !enable) begin
        k         = 0;
        exp_left  = sample_mid;
        exp_right = sample_mid;
      end
      enable = rows[r].enable;
      if (!rows[r].enable) begin
        repeat (rows[r].frames * frame_period) @(negedge clk_114);
        expect_idle();
      end else begin
        seen_underrun = 1'b0;
        for (int f = 0; f < rows[r].frames; f++) begin
          do begin
            @(negedge clk_114);
          end while (!sample_strobe);
          // Pair missing when fewer than two words came back
          starved = (delivered - k) < 2;
          match_flag("underrun", starved, underrun);
          seen_underrun = seen_underrun | underrun;
          if (!starved) begin
            exp_left  = stream_sample(k);
            exp_right = stream_sample(k + 1);
            k += 2;
          end
          compare_sample("left_sample", exp_left, left_sample);
          compare_sample("right_sample", exp_right, right_sample);
        end
        match_flag("underrun in row", rows[r].underrun, seen_underrun);
      end
      $display("Row %0d done: enable=%0b stall=%0b withhold=%0b frames=%0d, errors so far %0d",
               r, rows[r].enable, rows[r].stall, rows[r].withhold, rows[r].frames, errors);
    end
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, dut.u_properties.failures);
    if (errors == 0 && dut.u_properties.failures == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== aud_stream.f ====
source/aud_mem_pkg.sv
source/aud_sample_pkg.sv
source/aud_fetch.sv
source/aud_fifo.sv
source/aud_player.sv
source/aud_stream.sv
test/aud_stream_properties.sv
test/aud_stream_tb.sv

// ==== Bender.yml ====
package:
  name: aud_stream

sources:
  - source/aud_mem_pkg.sv
  - source/aud_sample_pkg.sv
  - source/aud_fetch.sv
  - source/aud_fifo.sv
  - source/aud_player.sv
  - source/aud_stream.sv
  - target: test
    files:
      - test/aud_stream_properties.sv
      - test/aud_stream_tb.sv
